// ==== all.f ====
riscv_pkg.sv
rv32_decoder.sv
rv32_regfile.sv
rv32_imm_gen.sv
rv32_alu.sv
rv32_core.sv
inst_mem.sv
data_mem.sv
riscv_system.sv
tb_clock_gen.sv
tb_riscv_system.sv

// ==== data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
    parameter int DEPTH = riscv_pkg::dmem_depth_default
) (
    input  logic                       CLK,
    input  logic                       we,
    input  logic [riscv_pkg::xlen-1:0] addr,    // byte address
    input  logic [riscv_pkg::xlen-1:0] wdata,
    output logic [riscv_pkg::xlen-1:0] rdata
);
    import riscv_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [xlen-1:0] mem [DEPTH];
    logic [AW-1:0]   widx;

    // word index, upper bits dropped so it wraps modulo DEPTH
    assign widx = addr[AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[widx] <= wdata;   // sw commits at edge
        end
    end

    assign rdata = mem[widx];     // lw data same cycle

endmodule

// ==== inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem #(
    parameter int DEPTH = riscv_pkg::imem_depth_default
) (
    input  logic                       CLK,
    input  logic                       prog_we,
    input  logic [$clog2(DEPTH)-1:0]   prog_addr,   // word index
    input  logic [riscv_pkg::xlen-1:0] prog_data,
    input  logic [riscv_pkg::xlen-1:0] iaddr,       // byte address
    output logic [riscv_pkg::xlen-1:0] idata
);
    import riscv_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [xlen-1:0] mem [DEPTH];

    // load port, used before run
    always_ff @(posedge CLK) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign idata = mem[iaddr[AW+1:2]];  // combinational fetch

endmodule

// ==== riscv_golden.txt ====
# P <word index> <instruction word>   program image, hex
# S <store address> <store data>      expected stores in execution order, hex
P 00 10000093  # addi x1, x0, 256
P 01 01900113  # addi x2, x0, 25
P 02 ff900193  # addi x3, x0, -7
P 03 40218233  # sub  x4, x3, x2
P 04 0040a023  # sw   x4, 0(x1)
P 05 0021a2b3  # slt  x5, x3, x2
P 06 0050a223  # sw   x5, 4(x1)
P 07 4011d313  # srai x6, x3, 1
P 08 0060a423  # sw   x6, 8(x1)
P 09 005113b3  # sll  x7, x2, x5
P 0a 0070a623  # sw   x7, 12(x1)
P 0b 0051d433  # srl  x8, x3, x5
P 0c 0080a823  # sw   x8, 16(x1)
P 0d 03c1f493  # andi x9, x3, 0x3c
P 0e 0090aa23  # sw   x9, 20(x1)
P 0f 0140a503  # lw   x10, 20(x1)
P 10 00a0ac23  # sw   x10, 24(x1)
P 11 06310013  # addi x0, x2, 99
P 12 0000ae23  # sw   x0, 28(x1)
P 13 00310463  # beq  x2, x3, +8   not taken
P 14 0220a023  # sw   x2, 32(x1)
P 15 00311463  # bne  x2, x3, +8   taken
P 16 0230a023  # sw   x3, 32(x1)   skipped
P 17 0021c463  # blt  x3, x2, +8   taken
P 18 0230a223  # sw   x3, 36(x1)   skipped
P 19 0021d463  # bge  x3, x2, +8   not taken
P 1a 0230a223  # sw   x3, 36(x1)
P 1b 008005ef  # jal  x11, +8
P 1c 0220a423  # sw   x2, 40(x1)   skipped
P 1d 02b0a423  # sw   x11, 40(x1)
P 1e 12345637  # lui  x12, 0x12345
P 1f 02c0a623  # sw   x12, 44(x1)
P 20 0000006f  # jal  x0, 0        halt loop
S 00000100 ffffffe0
S 00000104 00000001
S 00000108 fffffffc
S 0000010c 00000032
S 00000110 7ffffffc
S 00000114 00000038
S 00000118 00000038
S 0000011c 00000000
S 00000120 00000019
S 00000124 fffffff9
S 00000128 00000070
S 0000012c 12345000

// ==== riscv_pkg.sv ====
package riscv_pkg;

    // ************************************************************
    // widths and default memory depths
    // ************************************************************
    localparam int xlen               = 32;   // data and address width
    localparam int imem_depth_default = 256;  // words
    localparam int dmem_depth_default = 256;  // words

    // ************************************************************
    // opcode classes handled by the core
    // ************************************************************
    localparam logic [6:0] op     = 7'b0110011;  // register alu ops
    localparam logic [6:0] op_imm = 7'b0010011;  // immediate alu ops
    localparam logic [6:0] load   = 7'b0000011;  // lw only
    localparam logic [6:0] store  = 7'b0100011;  // sw only
    localparam logic [6:0] branch = 7'b1100011;  // beq bne blt bge
    localparam logic [6:0] jal    = 7'b1101111;
    localparam logic [6:0] lui    = 7'b0110111;

    // alu function select
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,   // signed compare
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_sra    = 4'd8,
        alu_pass_b = 4'd9    // lui forwards the immediate
    } alu_op_t;

    // immediate formats
    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_sel_t;

    // register writeback source
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2   // link value for jal
    } wb_sel_t;

endpackage

// ==== riscv_system.sv ====
`timescale 1ns/1ps

module riscv_system #(
    parameter int IMEM_DEPTH = riscv_pkg::imem_depth_default,
    parameter int DMEM_DEPTH = riscv_pkg::dmem_depth_default
) (
    input  logic                          CLK,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          prog_we,      // program load strobe
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,    // word index
    input  logic [riscv_pkg::xlen-1:0]    prog_data,
    output logic                          store_valid,  // store commits next edge
    output logic [riscv_pkg::xlen-1:0]    store_addr,
    output logic [riscv_pkg::xlen-1:0]    store_data
);
    import riscv_pkg::*;

    // instruction bus
    logic [xlen-1:0] iaddr;
    logic [xlen-1:0] idata;

    // data bus
    logic [xlen-1:0] daddr;
    logic [xlen-1:0] ddata_w;
    logic [xlen-1:0] ddata_r;
    logic            d_we;

    rv32_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_core (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .run     (run),
        .idata   (idata),
        .ddata_r (ddata_r),
        .iaddr   (iaddr),
        .daddr   (daddr),
        .ddata_w (ddata_w),
        .d_we    (d_we)
    );

    inst_mem #(.DEPTH(IMEM_DEPTH)) i_imem (
        .CLK       (CLK),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .iaddr     (iaddr),
        .idata     (idata)
    );

    data_mem #(.DEPTH(DMEM_DEPTH)) i_dmem (
        .CLK   (CLK),
        .we    (d_we),
        .addr  (daddr),
        .wdata (ddata_w),
        .rdata (ddata_r)
    );

    // store observation taps
    assign store_valid = d_we;
    assign store_addr  = daddr;
    assign store_data  = ddata_w;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_riscv_system -o tb_sim

# the simulator exits nonzero on failure, the grep below decides
out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Finished with no errors"; then
    exit 0
else
    exit 1
fi

// ==== rv32_alu.sv ====
`timescale 1ns/1ps

module rv32_alu (
    input  logic [riscv_pkg::xlen-1:0] a,
    input  logic [riscv_pkg::xlen-1:0] b,
    input  riscv_pkg::alu_op_t         alu_op,
    output logic [riscv_pkg::xlen-1:0] result,
    output logic                       eq,   // a == b
    output logic                       lt    // signed a < b
);
    import riscv_pkg::*;

    localparam int SHW = $clog2(xlen);   // shift amount width

    logic [SHW-1:0] shamt;

    assign shamt = b[SHW-1:0];   // upper bits of b ignored

    // ************************************************************
    // compare flags, also used for branch resolution
    // ************************************************************
    assign eq = (a == b);
    assign lt = ($signed(a) < $signed(b));

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt};
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;  // keeps sign
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// ==== rv32_core.sv ====
`timescale 1ns/1ps

module rv32_core #(
    parameter int IMEM_DEPTH = riscv_pkg::imem_depth_default,
    parameter int DMEM_DEPTH = riscv_pkg::dmem_depth_default
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       run,      // low holds pc at 0, blocks writes
    input  logic [riscv_pkg::xlen-1:0] idata,
    input  logic [riscv_pkg::xlen-1:0] ddata_r,
    output logic [riscv_pkg::xlen-1:0] iaddr,    // byte address
    output logic [riscv_pkg::xlen-1:0] daddr,
    output logic [riscv_pkg::xlen-1:0] ddata_w,
    output logic                       d_we
);
    import riscv_pkg::*;

    localparam int IAW = $clog2(IMEM_DEPTH) + 2;  // byte address bits into imem
    localparam int DAW = $clog2(DMEM_DEPTH) + 2;  // byte address bits into dmem

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;   // branch or jump destination
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] rdata1, rdata2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;
    logic            eq, lt;
    logic            br_cond;
    logic            rf_we;

    // decoded controls
    alu_op_t  alu_op;
    imm_sel_t imm_sel;
    wb_sel_t  wb_sel;
    logic     alu_src_imm, reg_we, mem_we, is_branch, is_jal;

    // ************************************************************
    // program counter
    // ************************************************************
    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;    // b or j immediate, picked by decoder

    always_comb begin
        case (idata[14:12])         // branch type from funct3
            3'b000:  br_cond = eq;  // beq
            3'b001:  br_cond = !eq; // bne
            3'b100:  br_cond = lt;  // blt
            3'b101:  br_cond = !lt; // bge
            default: br_cond = 1'b0;
        endcase
    end

    assign pc_next = (is_jal || (is_branch && br_cond)) ? pc_target : pc_plus4;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;                                         // parked at reset vector
        end else begin
            pc <= {{(xlen-IAW){1'b0}}, pc_next[IAW-1:0]};    // wraps inside imem
        end
    end

    assign iaddr = pc;

    // ************************************************************
    // datapath
    // ************************************************************
    rv32_decoder i_dec (
        .instr       (idata),
        .alu_op      (alu_op),
        .imm_sel     (imm_sel),
        .alu_src_imm (alu_src_imm),
        .reg_we      (reg_we),
        .mem_we      (mem_we),
        .wb_sel      (wb_sel),
        .is_branch   (is_branch),
        .is_jal      (is_jal)
    );

    assign rf_we = reg_we && run;

    rv32_regfile i_rf (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .we     (rf_we),
        .rs1    (idata[19:15]),
        .rs2    (idata[24:20]),
        .rd     (idata[11:7]),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv32_imm_gen i_imm (
        .instr   (idata),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    assign alu_b = alu_src_imm ? imm : rdata2;  // operand b mux

    rv32_alu i_alu (
        .a      (rdata1),
        .b      (alu_b),
        .alu_op (alu_op),
        .result (alu_result),
        .eq     (eq),
        .lt     (lt)
    );

    // writeback source
    always_comb begin
        case (wb_sel)
            wb_mem:  wb_data = ddata_r;    // lw
            wb_pc4:  wb_data = pc_plus4;   // jal link
            default: wb_data = alu_result;
        endcase
    end

    // data bus, address trimmed to dmem range
    assign daddr   = {{(xlen-DAW){1'b0}}, alu_result[DAW-1:0]};
    assign ddata_w = rdata2;
    assign d_we    = mem_we && run;

endmodule

// ==== rv32_decoder.sv ====
`timescale 1ns/1ps

module rv32_decoder (
    input  logic [riscv_pkg::xlen-1:0] instr,
    output riscv_pkg::alu_op_t         alu_op,
    output riscv_pkg::imm_sel_t        imm_sel,
    output logic                       alu_src_imm,  // b operand from immediate
    output logic                       reg_we,
    output logic                       mem_we,
    output riscv_pkg::wb_sel_t         wb_sel,
    output logic                       is_branch,
    output logic                       is_jal
);
    import riscv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;   // sub and sra select bit

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    always_comb begin
        // defaults give a no-op that falls through to pc+4
        alu_op      = alu_add;
        imm_sel     = imm_i;
        alu_src_imm = 1'b0;
        reg_we      = 1'b0;
        mem_we      = 1'b0;
        wb_sel      = wb_alu;
        is_branch   = 1'b0;
        is_jal      = 1'b0;

        case (opcode)
            op, op_imm: begin
                alu_src_imm = (opcode == op_imm);
                reg_we      = 1'b1;
                case (funct3)
                    3'b000:  alu_op = (opcode == op && funct7_5) ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7_5 ? alu_sra : alu_srl;  // srai shares bit 30
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: reg_we = 1'b0;  // sltu not in subset
                endcase
            end
            load: begin
                alu_src_imm = 1'b1;   // rs1 + imm_i
                reg_we      = 1'b1;
                wb_sel      = wb_mem;
            end
            store: begin
                imm_sel     = imm_s;
                alu_src_imm = 1'b1;
                mem_we      = 1'b1;
            end
            branch: begin
                imm_sel   = imm_b;    // target offset, alu compares rs1 and rs2
                is_branch = 1'b1;
            end
            jal: begin
                imm_sel = imm_j;
                reg_we  = 1'b1;
                wb_sel  = wb_pc4;
                is_jal  = 1'b1;
            end
            lui: begin
                imm_sel     = imm_u;
                alu_src_imm = 1'b1;
                alu_op      = alu_pass_b;
                reg_we      = 1'b1;
            end
            default: ;              // unknown opcode
        endcase
    end

endmodule

// ==== rv32_imm_gen.sv ====
`timescale 1ns/1ps

module rv32_imm_gen (
    input  logic [riscv_pkg::xlen-1:0] instr,
    input  riscv_pkg::imm_sel_t        imm_sel,
    output logic [riscv_pkg::xlen-1:0] imm
);
    import riscv_pkg::*;

    logic sign;

    assign sign = instr[31];  // all formats sign extend from bit 31

    always_comb begin
        case (imm_sel)
            imm_s: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            imm_b: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            imm_u: begin
                imm = {instr[31:12], 12'b0};   // zeros below
            end
            imm_j: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, instr[31:20]};   // i format
            end
        endcase
    end

endmodule

// ==== rv32_regfile.sv ====
`timescale 1ns/1ps

module rv32_regfile (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       we,
    input  logic [4:0]                 rs1,
    input  logic [4:0]                 rs2,
    input  logic [4:0]                 rd,
    input  logic [riscv_pkg::xlen-1:0] wdata,
    output logic [riscv_pkg::xlen-1:0] rdata1,
    output logic [riscv_pkg::xlen-1:0] rdata2
);
    import riscv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin  // x0 never written
            regs[rd] <= wdata;
        end
    end

    // combinational reads, x0 forced to zero
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8   // full clock period
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;   // known level at time 0
    end

    // half period high, half low
    always #(PERIOD_NS / 2) CLK = ~CLK;

endmodule

// ==== tb_riscv_system.sv ====
`timescale 1ns/1ps

module tb_riscv_system;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int PAW        = $clog2(IMEM_DEPTH);  // program load index width
    localparam int PERIOD_NS  = 8;
    localparam int DRIVE_DLY  = 1;                   // input skew after rising edge
    localparam int TAIL_CYCLES = 20;                 // idle time to catch late extra stores

    logic            CLK;
    logic            rst_n;
    logic            run;
    logic            prog_we;
    logic [PAW-1:0]  prog_addr;
    logic [31:0]     prog_data;
    logic            store_valid;
    logic [31:0]     store_addr;
    logic [31:0]     store_data;

    // golden contents
    logic [31:0] prog_idx[$];
    logic [31:0] prog_word[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];

    int   n_seen;          // stores matched so far
    logic golden_loaded;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS)) i_clk (
        .CLK (CLK)
    );

    riscv_system #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_dut (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .run         (run),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    // ************************************************************
    // failure handling
    // ************************************************************
    task automatic abort_run(input string why);
        $display("%s (at %0t ns)", why, $time);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "simulation stopped");
        end
    endtask

    // ************************************************************
    // golden file and program load
    // ************************************************************
    task automatic read_golden();
        int          fd;
        int          cnt;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("riscv_golden.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the golden file riscv_golden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.getc(0) != "#") begin   // skip comments
                    cnt = $sscanf(line, "%c %h %h", tag, a, b);
                    if (cnt != 3) begin
                        abort_run({"badly formed golden line: ", line});
                    end else if (tag == "P") begin
                        prog_idx.push_back(a);
                        prog_word.push_back(b);
                    end else if (tag == "S") begin
                        exp_addr.push_back(a);   // expected in program order
                        exp_data.push_back(b);
                    end else begin
                        abort_run({"unknown tag in golden line: ", line});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_program();
        logic [31:0] idx;
        foreach (prog_word[i]) begin
            idx = prog_idx[i];
            @(posedge CLK);
            #(DRIVE_DLY);
            prog_we   = 1'b1;
            prog_addr = idx[PAW-1:0];   // word index
            prog_data = prog_word[i];
        end
        @(posedge CLK);
        #(DRIVE_DLY);
        prog_we = 1'b0;   // last word written at that edge
    endtask

    // ************************************************************
    // store monitor sampled mid cycle where outputs are settled
    // ************************************************************
    always @(negedge CLK) begin
        if (!run) begin
            check_equal("store_valid while run is low", {31'b0, store_valid}, 32'd0);
        end else if (store_valid !== 1'b0) begin
            if (n_seen >= exp_addr.size()) begin
                abort_run("the core made a store beyond the expected list");
            end else begin
                check_equal($sformatf("store %0d address", n_seen), store_addr,
                            exp_addr[n_seen]);
                check_equal($sformatf("store %0d data", n_seen), store_data,
                            exp_data[n_seen]);
                n_seen++;
            end
        end
    end

    // watchdog budget scales with program length
    initial begin
        int limit;
        wait (golden_loaded);
        limit = 4 * prog_word.size() + 200;
        repeat (limit) @(posedge CLK);
        abort_run($sformatf("timeout: only %0d of %0d expected stores arrived",
                            n_seen, exp_addr.size()));
    end

    // ************************************************************
    // main sequence
    // ************************************************************
    initial begin
        rst_n         = 1'b0;   // reset from time 0
        run           = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        n_seen        = 0;
        golden_loaded = 1'b0;

        read_golden();
        golden_loaded = 1'b1;

        repeat (3) @(posedge CLK);
        #(DRIVE_DLY);
        rst_n = 1'b1;

        load_program();   // core parked at pc 0 meanwhile

        @(posedge CLK);
        #(DRIVE_DLY);
        run = 1'b1;

        wait (n_seen == exp_addr.size());
        repeat (TAIL_CYCLES) @(posedge CLK);   // program spins on its final jal
        $display("Finished with no errors");
        $finish;
    end

endmodule
